/* verilog.f */
+incdir+hdl
hdl/simd_pkg.sv
hdl/simd_issue_if.sv
hdl/simd_issue_ctrl.sv
hdl/simd_score_board.sv
hdl/simd_wb_pipe.sv
hdl/simd_issue_unit.sv
tb/simd_issue_unit_assert.sv
tb/simd_issue_unit_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := simd_issue_unit_tb
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
PASS_MSG   := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the simulation printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb/simd_issue_unit_tb.sv */
// Random-stimulus testbench for the SIMD issue unit
// A reference model predicts accept, stall, writeback and busy in every cycle

`include "simd_settings.svh"

module simd_issue_unit_tb;
    import simd_pkg::*;

    localparam int PERIOD       = 20;
    localparam int RST_CYCLES   = 3;
    localparam int SWEEP_CYCLES = 80;    // 20 opcodes times 4 SEW values
    localparam int DRAIN_CYCLES = 8;
    localparam int RAND_CYCLES  = 3000;
    localparam int FLUSH_ROUNDS = 40;
    localparam int ROUND_CYCLES = 12;    // 8 busy, 1 flush, 3 idle
    localparam int DEPTH        = `SIMD_MAX_STAGES + 1;
    localparam int TOTAL_CYCLES = RST_CYCLES + SWEEP_CYCLES + RAND_CYCLES
                                + 2 * DRAIN_CYCLES + FLUSH_ROUNDS * ROUND_CYCLES;
    localparam int TIMEOUT      = (TOTAL_CYCLES + 100) * PERIOD;

    logic                   clk;
    logic                   rstn;
    logic                   flush;
    logic                   instr_valid;
    unit_e                  instr_unit;
    simd_op_e               instr_op;
    sew_e                   instr_sew;
    logic [`SIMD_TAG_W-1:0] instr_tag;
    logic                   stall;
    logic                   accept;
    logic [3:0]             exe_stages;
    logic                   wb_valid;
    logic [`SIMD_TAG_W-1:0] wb_tag;
    simd_op_e               wb_op;
    logic                   busy;

    // Future writebacks, entry k lands k cycles after the current one
    logic                   slot_valid [DEPTH];
    logic [`SIMD_TAG_W-1:0] slot_tag   [DEPTH];
    simd_op_e               slot_op    [DEPTH];

    logic [`SIMD_TAG_W-1:0] next_tag;  // Tag for the next valid input

    integer seed;
    int     errors;
    int     test_errors;
    int     cycles_checked;
    int     tests_done;

    simd_issue_unit u_simd_issue_unit (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .flush_i       (flush),
        .instr_valid_i (instr_valid),
        .instr_unit_i  (instr_unit),
        .instr_op_i    (instr_op),
        .instr_sew_i   (instr_sew),
        .instr_tag_i   (instr_tag),
        .stall_o       (stall),
        .accept_o      (accept),
        .exe_stages_o  (exe_stages),
        .wb_valid_o    (wb_valid),
        .wb_tag_o      (wb_tag),
        .wb_op_o       (wb_op),
        .busy_o        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Latency table for VLEN 128
    function automatic logic [3:0] expected_latency(input simd_op_e op, input sew_e sew);
        case (op)
            VMUL, VMULH, VMULHU, VMULHSU, VWMUL, VWMULU, VWMULSU:
                return (sew == SEW_64) ? 4'd3 : 4'd2;
            VMACC, VNMSAC, VMADD, VNMSUB:
                return (sew == SEW_64) ? 4'd4 : 4'd3;
            VREDSUM, VREDAND, VREDOR, VREDXOR: begin
                if (sew == SEW_64) return 4'd3;
                if (sew == SEW_32) return 4'd4;
                return 4'd5;  // 16 or 8 elements per lane group
            end
            default: return 4'd1;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        test_errors++;
    endtask

    // Drive on the falling edge, check a quarter period later, then step the model
    task automatic run_cycle(input logic valid, input unit_e unit, input simd_op_e op,
                             input sew_e sew, input logic flush_req);
        logic [3:0] lat;
        logic       req;
        logic       exp_accept;
        logic       exp_stall;
        logic       exp_busy;
        @(negedge clk);
        instr_valid = valid;
        instr_unit  = unit;
        instr_op    = op;
        instr_sew   = sew;
        instr_tag   = next_tag;
        flush       = flush_req;
        #(PERIOD / 4);
        lat        = expected_latency(op, sew);
        req        = valid && (unit == UNIT_SIMD) && !flush_req;
        exp_accept = req && !slot_valid[lat];  // Writeback cycle already taken
        exp_stall  = req && !exp_accept;
        exp_busy   = 1'b0;
        for (int k = 0; k < DEPTH; k++) begin
            exp_busy = exp_busy | slot_valid[k];
        end
        cycles_checked++;
        if (exe_stages !== lat) report_mismatch("exe_stages_o", 32'(lat), 32'(exe_stages));
        if (accept !== exp_accept) report_mismatch("accept_o", 32'(exp_accept), 32'(accept));
        if (stall !== exp_stall) report_mismatch("stall_o", 32'(exp_stall), 32'(stall));
        if (busy !== exp_busy) report_mismatch("busy_o", 32'(exp_busy), 32'(busy));
        if (wb_valid !== slot_valid[0]) begin
            report_mismatch("wb_valid_o", 32'(slot_valid[0]), 32'(wb_valid));
        end
        if (slot_valid[0] && wb_tag !== slot_tag[0]) begin
            report_mismatch("wb_tag_o", 32'(slot_tag[0]), 32'(wb_tag));
        end
        if (slot_valid[0] && wb_op !== slot_op[0]) begin
            report_mismatch("wb_op_o", 32'(slot_op[0]), 32'(wb_op));
        end
        if (flush_req) begin
            for (int k = 0; k < DEPTH; k++) begin
                slot_valid[k] = 1'b0;
            end
        end else begin
            if (exp_accept) begin
                slot_valid[lat] = 1'b1;
                slot_tag[lat]   = instr_tag;
                slot_op[lat]    = op;
            end
            for (int k = 0; k < DEPTH - 1; k++) begin
                slot_valid[k] = slot_valid[k+1];
                slot_tag[k]   = slot_tag[k+1];
                slot_op[k]    = slot_op[k+1];
            end
            slot_valid[DEPTH-1] = 1'b0;
        end
        if (valid) next_tag++;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            run_cycle(1'b0, UNIT_ALU, VADD, SEW_8, 1'b0);
        end
    endtask

    // Percentages for valid, SIMD unit and flush
    task automatic random_cycle(input int valid_pct, input int simd_pct, input int flush_pct);
        logic     valid;
        unit_e    unit;
        simd_op_e op;
        sew_e     sew;
        logic     flush_req;
        valid     = ({$random(seed)} % 100) < valid_pct;
        unit      = unit_e'(2'({$random(seed)} % 2));  // ALU or MEM
        if (({$random(seed)} % 100) < simd_pct) unit = UNIT_SIMD;
        op        = simd_op_e'(5'({$random(seed)} % 20));
        sew       = sew_e'(2'({$random(seed)} % 4));
        flush_req = ({$random(seed)} % 100) < flush_pct;
        run_cycle(valid, unit, op, sew, flush_req);
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, test_errors);
        errors      += test_errors;
        test_errors  = 0;
        tests_done++;
    endtask

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed           = 44;
        errors         = 0;
        test_errors    = 0;
        cycles_checked = 0;
        tests_done     = 0;
        rstn           = 1'b0;
        flush          = 1'b0;
        instr_valid    = 1'b0;
        instr_unit     = UNIT_ALU;
        instr_op       = VADD;
        instr_sew      = SEW_8;
        instr_tag      = '0;
        next_tag       = '0;
        for (int k = 0; k < DEPTH; k++) begin
            slot_valid[k] = 1'b0;
            slot_tag[k]   = '0;
            slot_op[k]    = VADD;
        end
        repeat (RST_CYCLES) @(negedge clk);
        rstn = 1'b1;

        // Every opcode at every SEW, back to back
        for (int o = 0; o < 20; o++) begin
            for (int s = 0; s < 4; s++) begin
                run_cycle(1'b1, UNIT_SIMD, simd_op_e'(5'(o)), sew_e'(2'(s)), 1'b0);
            end
        end
        idle_cycles(DRAIN_CYCLES);
        end_test("latency_sweep");

        for (int i = 0; i < RAND_CYCLES; i++) begin
            random_cycle(70, 80, 3);
        end
        idle_cycles(DRAIN_CYCLES);
        end_test("random_traffic");

        // Fill the pipe, flush with a live request, then expect silence
        for (int r = 0; r < FLUSH_ROUNDS; r++) begin
            for (int i = 0; i < 8; i++) begin
                random_cycle(100, 100, 0);
            end
            random_cycle(100, 100, 100);
            idle_cycles(3);
        end
        end_test("flush_rounds");

        $display("tests %0d, cycles checked %0d, errors %0d",
                 tests_done, cycles_checked, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb/simd_issue_unit_assert.sv */
// Concurrent checks on stall, flush and reset behaviour of the issue unit
// Bound into every simd_issue_unit instance

module simd_issue_unit_assert (
    input logic clk_i,
    input logic rstn_i,
    input logic flush_i,
    input logic stall_i,
    input logic accept_i,
    input logic wb_valid_i,
    input logic busy_i
);

    // A request is either issued or refused, never both
    a_stall_accept_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(stall_i && accept_i))
        else $error("stall and accept high in the same cycle");

    // Flushed slots must not reach the writeback port
    a_no_wb_after_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> !wb_valid_i)
        else $error("writeback seen in the cycle after a flush");

    a_idle_after_reset: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> (!busy_i && !wb_valid_i && !stall_i))
        else $error("unit not idle when reset is released");

endmodule

bind simd_issue_unit simd_issue_unit_assert u_assert (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .flush_i    (flush_i),
    .stall_i    (stall_o),
    .accept_i   (accept_o),
    .wb_valid_i (wb_valid_o),
    .busy_i     (busy_o)
);

/* hdl/simd_issue_unit.sv */
// Top level of the SIMD issue scoreboard
// Issue control, occupancy board and writeback pipe joined by one bundle

`include "simd_settings.svh"

module simd_issue_unit (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,

    input  logic                   instr_valid_i,
    input  simd_pkg::unit_e        instr_unit_i,
    input  simd_pkg::simd_op_e     instr_op_i,
    input  simd_pkg::sew_e         instr_sew_i,
    input  logic [`SIMD_TAG_W-1:0] instr_tag_i,

    output logic                   stall_o,
    output logic                   accept_o,
    output logic [3:0]             exe_stages_o,
    output logic                   wb_valid_o,
    output logic [`SIMD_TAG_W-1:0] wb_tag_o,
    output simd_pkg::simd_op_e     wb_op_o,
    output logic                   busy_o
);
    import simd_pkg::*;

    logic                   board_stall;
    logic                   pipe_wb_valid;
    logic [`SIMD_TAG_W-1:0] pipe_wb_tag;
    simd_op_e               pipe_wb_op;

    simd_issue_if u_issue_if ();

    simd_issue_ctrl u_issue_ctrl (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .instr_unit_i  (instr_unit_i),
        .instr_op_i    (instr_op_i),
        .instr_sew_i   (instr_sew_i),
        .instr_tag_i   (instr_tag_i),
        .ifc           (u_issue_if.ctrl),
        .stall_i       (board_stall),
        .wb_valid_i    (pipe_wb_valid),
        .wb_tag_i      (pipe_wb_tag),
        .wb_op_i       (pipe_wb_op),
        .stall_o       (stall_o),
        .accept_o      (accept_o),
        .exe_stages_o  (exe_stages_o),
        .wb_valid_o    (wb_valid_o),
        .wb_tag_o      (wb_tag_o),
        .wb_op_o       (wb_op_o),
        .busy_o        (busy_o)
    );

    simd_score_board u_score_board (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (flush_i),
        .ifc     (u_issue_if.board),
        .stall_o (board_stall)
    );

    simd_wb_pipe u_wb_pipe (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .flush_i    (flush_i),
        .ifc        (u_issue_if.pipe),
        .wb_valid_o (pipe_wb_valid),
        .wb_tag_o   (pipe_wb_tag),
        .wb_op_o    (pipe_wb_op)
    );

endmodule

/* hdl/simd_wb_pipe.sv */
// Delay rows that carry tag and opcode of each issued instruction
// to the single writeback port after its latency

`include "simd_settings.svh"

module simd_wb_pipe (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,

    simd_issue_if.pipe             ifc,

    output logic                   wb_valid_o,
    output logic [`SIMD_TAG_W-1:0] wb_tag_o,
    output simd_pkg::simd_op_e     wb_op_o
);
    import simd_pkg::*;

    localparam int MAX_STAGES = `SIMD_MAX_STAGES;
    localparam int TAG_W      = `SIMD_TAG_W;
    localparam int OP_W       = $bits(simd_op_e);

    logic [MAX_STAGES:1]            last_valid;
    logic [MAX_STAGES:1][TAG_W-1:0] last_tag;
    logic [MAX_STAGES:1][OP_W-1:0]  last_op;
    logic [TAG_W-1:0]               tag_sel;
    logic [OP_W-1:0]                op_sel;

    // Same row shape as the scoreboard, slot i-1 is the writeback slot
    for (genvar i = 1; i <= MAX_STAGES; i++) begin : g_row
        logic [i-1:0]     valid_q;
        logic [TAG_W-1:0] tag_q [i];
        simd_op_e         op_q  [i];

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                valid_q <= '0;
            end else if (flush_i) begin
                valid_q <= '0;  // Flushed work never reaches writeback
            end else begin
                valid_q[0] <= ifc.accept && (ifc.req_stages == 4'(i));
                for (int j = 1; j < i; j++) begin
                    valid_q[j] <= valid_q[j-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (ifc.accept && (ifc.req_stages == 4'(i))) begin
                tag_q[0] <= ifc.tag;
                op_q[0]  <= ifc.op;
            end
            for (int j = 1; j < i; j++) begin
                tag_q[j] <= tag_q[j-1];
                op_q[j]  <= op_q[j-1];
            end
        end

        assign last_valid[i] = valid_q[i-1];
        assign last_tag[i]   = tag_q[i-1];
        assign last_op[i]    = op_q[i-1];
    end

    // At most one row ends per cycle, so an AND-OR mux is enough
    always_comb begin
        tag_sel = '0;
        op_sel  = '0;
        for (int i = 1; i <= MAX_STAGES; i++) begin
            tag_sel = tag_sel | (last_tag[i] & {TAG_W{last_valid[i]}});
            op_sel  = op_sel | (last_op[i] & {OP_W{last_valid[i]}});
        end
    end

    assign wb_valid_o = |last_valid;
    assign wb_tag_o   = tag_sel;
    assign wb_op_o    = simd_op_e'(op_sel);

endmodule

/* hdl/simd_score_board.sv */
// Writeback occupancy tracker: one shift row per latency
// Flags a request that would reach writeback together with an older one

`include "simd_settings.svh"

module simd_score_board (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        flush_i,

    simd_issue_if.board ifc,

    output logic        stall_o
);
    localparam int MAX_STAGES = `SIMD_MAX_STAGES;

    logic [MAX_STAGES:1] row_hit;

    /*
     * Row i has i slots. An instruction sits in slot j during the
     * (j+1)-th cycle after issue and writes back while in slot i-1,
     * so slot j is i-1-j cycles away from writeback.
     */
    for (genvar i = 1; i <= MAX_STAGES; i++) begin : g_row
        logic [i-1:0] slot_q;
        logic         hit;

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                slot_q <= '0;
            end else if (flush_i) begin
                slot_q <= '0;
            end else begin
                slot_q[0] <= ifc.accept && (ifc.req_stages == 4'(i));
                for (int j = 1; j < i; j++) begin
                    slot_q[j] <= slot_q[j-1];  // Advance one slot per cycle
                end
            end
        end

        // Last slot is writing back now and never blocks a new request
        always_comb begin
            hit = 1'b0;
            for (int j = 0; j < i - 1; j++) begin
                if (ifc.req_stages == 4'(i - 1 - j)) begin
                    hit = slot_q[j];
                end
            end
        end

        assign row_hit[i] = hit;
    end

    // Single writeback port, any row landing on the same cycle blocks
    assign stall_o = |row_hit;

endmodule

/* hdl/simd_issue_ctrl.sv */
// Issue control for the SIMD unit: latency decode, accept or stall,
// in-flight counting and the writeback outputs of the unit

`include "simd_settings.svh"

module simd_issue_ctrl (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,

    input  logic                   instr_valid_i,
    input  simd_pkg::unit_e        instr_unit_i,
    input  simd_pkg::simd_op_e     instr_op_i,
    input  simd_pkg::sew_e         instr_sew_i,
    input  logic [`SIMD_TAG_W-1:0] instr_tag_i,

    simd_issue_if.ctrl             ifc,

    input  logic                   stall_i,     // Writeback slot already taken
    input  logic                   wb_valid_i,
    input  logic [`SIMD_TAG_W-1:0] wb_tag_i,
    input  simd_pkg::simd_op_e     wb_op_i,

    output logic                   stall_o,
    output logic                   accept_o,
    output logic [3:0]             exe_stages_o,
    output logic                   wb_valid_o,
    output logic [`SIMD_TAG_W-1:0] wb_tag_o,
    output simd_pkg::simd_op_e     wb_op_o,
    output logic                   busy_o
);
    import simd_pkg::*;

    logic [3:0] exe_stages;
    logic [2:0] inflight_q;  // At most five in flight

    assign exe_stages = simd_latency(instr_op_i, instr_sew_i);

    // Only SIMD work is tracked here, flush blocks issue in its own cycle
    assign ifc.req_valid  = instr_valid_i & (instr_unit_i == UNIT_SIMD) & ~flush_i;
    assign ifc.req_stages = exe_stages;
    assign ifc.op         = instr_op_i;
    assign ifc.tag        = instr_tag_i;
    assign ifc.accept     = ifc.req_valid & ~stall_i;

    // Issue and retire in the same cycle leave the count unchanged
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            inflight_q <= '0;
        end else if (flush_i) begin
            inflight_q <= '0;  // All slots dropped at this edge
        end else if (ifc.accept && !wb_valid_i) begin
            inflight_q <= inflight_q + 3'd1;
        end else if (!ifc.accept && wb_valid_i) begin
            inflight_q <= inflight_q - 3'd1;
        end
    end

    assign stall_o      = ifc.req_valid & stall_i;
    assign accept_o     = ifc.accept;
    assign exe_stages_o = exe_stages;  // Shown even without a request

    assign wb_valid_o = wb_valid_i;
    assign wb_tag_o   = wb_tag_i;
    assign wb_op_o    = wb_op_i;

    assign busy_o = |inflight_q;

endmodule

/* hdl/simd_issue_if.sv */
// Request and acceptance bundle from issue control
// Read by the scoreboard and by the writeback delay pipe

`include "simd_settings.svh"

interface simd_issue_if;
    import simd_pkg::*;

    logic                   req_valid;   // SIMD request, no flush
    logic [3:0]             req_stages;  // Latency of the request
    logic                   accept;      // Request issued this cycle
    simd_op_e               op;
    logic [`SIMD_TAG_W-1:0] tag;

    modport ctrl (
        output req_valid,
        output req_stages,
        output accept,
        output op,
        output tag
    );

    // Occupancy only needs where the request lands
    modport board (
        input req_stages,
        input accept
    );

    modport pipe (
        input accept,
        input req_stages,
        input op,
        input tag
    );

endinterface

/* hdl/simd_pkg.sv */
// Types and latency rule shared by the SIMD issue unit
// Blocks import it in their body, ports use scoped names

`include "simd_settings.svh"

package simd_pkg;

    localparam int RED_STAGES = `SIMD_MAX_STAGES;  // Reduction tree depth at SEW 8

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MEM,
        UNIT_SIMD
    } unit_e;

    typedef enum logic [4:0] {
        VADD, VSUB, VAND, VOR, VXOR,
        VMUL, VMULH, VMULHU, VMULHSU,
        VWMUL, VWMULU, VWMULSU,
        VMACC, VNMSAC, VMADD, VNMSUB,
        VREDSUM, VREDAND, VREDOR, VREDXOR
    } simd_op_e;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_e;

    // Execution latency in cycles, 1 up to RED_STAGES
    function automatic logic [3:0] simd_latency(input simd_op_e op, input sew_e sew);
        logic [3:0] lat;
        case (op)
            VMUL, VMULH, VMULHU, VMULHSU, VWMUL, VWMULU, VWMULSU: begin
                lat = (sew == SEW_64) ? 4'd3 : 4'd2;
            end
            VMACC, VNMSAC, VMADD, VNMSUB: begin
                lat = (sew == SEW_64) ? 4'd4 : 4'd3;
            end
            VREDSUM, VREDAND, VREDOR, VREDXOR: begin
                // Fewer elements per register means a shallower tree
                case (sew)
                    SEW_8, SEW_16: lat = 4'(RED_STAGES);
                    SEW_32:        lat = 4'(RED_STAGES - 1);
                    default:       lat = 4'(RED_STAGES - 2);
                endcase
            end
            default: lat = 4'd1;  // Plain element-wise ops
        endcase
        return lat;
    endfunction

endpackage

/* hdl/simd_settings.svh */
// Global sizing for the SIMD issue unit
// Included by the package and by every block that sizes rows or tags

`ifndef SIMD_SETTINGS_SVH
`define SIMD_SETTINGS_SVH

// Vector register length in bits
`define SIMD_VLEN 128

// Instruction tag width
`define SIMD_TAG_W 4

// Longest execution latency, a reduction at the smallest SEW
// Also the number of scoreboard rows
`define SIMD_MAX_STAGES ($clog2(`SIMD_VLEN / 8) + 1)

`endif
